// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cache_dir
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
DATA      := lookup_cases.txt

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(DATA)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: cache_dir.sv
// cache tag directory top
`timescale 1ns/10ps
`default_nettype none

module cache_dir #(
    parameter int NUM_WAYS = 4 // 2 or 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_pkg::lookup_req_t  req,
    output cpu_pkg::lookup_resp_t resp
);

    import cache_pkg::*;

    logic [NUM_WAYS-1:0] hit_ways;
    logic [NUM_WAYS-1:0] valid_ways;
    tag_t                way_tags [NUM_WAYS];
    logic                fill;
    logic [INDEX_W-1:0]  fill_index;
    way_idx_t            fill_way;

    tag_array #(
        .NUM_WAYS (NUM_WAYS)
    ) u_tag_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (req.addr.index),
        .tag        (req.addr.tag),
        .fill       (fill),
        .fill_index (fill_index),
        .fill_way   (fill_way),
        .hit_ways   (hit_ways),
        .valid_ways (valid_ways),
        .way_tags   (way_tags)
    );

    lookup_ctrl #(
        .NUM_WAYS (NUM_WAYS)
    ) u_lookup_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .hit_ways   (hit_ways),
        .valid_ways (valid_ways),
        .way_tags   (way_tags),
        .fill       (fill),
        .fill_index (fill_index),
        .fill_way   (fill_way),
        .resp       (resp)
    );

endmodule

`default_nettype wire

// File: cache_pkg.sv
// cache geometry and address types
`default_nettype none

package cache_pkg;

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 4;   // 16-byte line
    localparam int INDEX_W  = 4;
    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    localparam int MAX_WAYS = 4;   // widest config the way field covers
    localparam int WAY_W    = $clog2(MAX_WAYS);

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [WAY_W-1:0] way_idx_t;

    typedef struct packed {
        tag_t                tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

endpackage

`default_nettype wire

// File: cpu_pkg.sv
// cpu lookup request and response
`default_nettype none

package cpu_pkg;

    typedef struct packed {
        logic                  valid;  // one-cycle lookup strobe
        cache_pkg::cache_addr_t addr;
    } lookup_req_t;

    // returned one cycle after the request
    typedef struct packed {
        logic                valid;
        logic                hit;
        cache_pkg::way_idx_t way;        // hit way, or filled way on a miss
        logic                evict;      // miss replaced a valid line
        cache_pkg::tag_t     victim_tag; // only meaningful with evict
    } lookup_resp_t;

endpackage

`default_nettype wire

// File: filelist.f
cache_pkg.sv
cpu_pkg.sv
plru.sv
tag_array.sv
lookup_ctrl.sv
cache_dir.sv
tb_cache_dir.sv

// File: lookup_cases.txt
// columns (hex): address, expected hit, way, evict, victim tag
// victim tag is compared only when evict is 1, otherwise 000000
// set 3 cold fills, lowest invalid way first
00A00130 0 0 0 000000
00A00230 0 1 0 000000
00A00330 0 2 0 000000
00A00430 0 3 0 000000
// same tags hit in their ways
00A00134 1 0 0 000000
00A00238 1 1 0 000000
00A0033C 1 2 0 000000
00A00430 1 3 0 000000
// replacement follows the tree
00A00530 0 0 1 00A001
00A00230 1 1 0 000000
00A00630 0 2 1 00A003
00A00530 1 0 0 000000
00A00130 0 3 1 00A004
00A00330 0 1 1 00A002
// fill seen by the very next request
00A00230 0 2 1 00A006
00A00230 1 2 0 000000
00A00430 0 0 1 00A005
00A00430 1 0 0 000000
// set 7 fills, set 3 tag misses here
00A00270 0 0 0 000000
00B00170 0 1 0 000000
00B00270 0 2 0 000000
00B00370 0 3 0 000000
// set 3 state untouched by set 7 traffic
00A00130 1 3 0 000000
00A00330 1 1 0 000000
00A00530 0 2 1 00A002
00B00470 0 0 1 00A002
00B00170 1 1 0 000000
// sets 3 and 7 interleaved
00A00430 1 0 0 000000
00B00570 0 2 1 00B002
00A00630 0 3 1 00A001
00B00270 0 0 1 00B004
// fresh sets 0 and 15, offset ignored
00C0010C 0 0 0 000000
FFFFFFF4 0 0 0 000000
00C00108 1 0 0 000000
FFFFFFF0 1 0 0 000000
00B00370 1 3 0 000000
00A00338 1 1 0 000000

// File: lookup_ctrl.sv
// lookup control and replacement
`timescale 1ns/10ps
`default_nettype none

module lookup_ctrl #(
    parameter int NUM_WAYS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  cpu_pkg::lookup_req_t          req,
    input  logic [NUM_WAYS-1:0]           hit_ways,
    input  logic [NUM_WAYS-1:0]           valid_ways,
    input  cache_pkg::tag_t               way_tags [NUM_WAYS],
    output logic                          fill,
    output logic [cache_pkg::INDEX_W-1:0] fill_index,
    output cache_pkg::way_idx_t           fill_way,
    output cpu_pkg::lookup_resp_t         resp
);

    import cache_pkg::*;
    import cpu_pkg::*;

    way_idx_t            lru_set [NUM_SETS];
    logic                hit;
    way_idx_t            hit_way;
    way_idx_t            first_inv;
    way_idx_t            victim_way;
    logic                victim_valid;
    tag_t                victim_tag;
    logic [NUM_WAYS-1:0] access;
    lookup_resp_t        resp_d;

    assign hit = |hit_ways;

    always_comb begin
        hit_way   = '0;
        first_inv = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_ways[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_ways[w]) begin
                first_inv = way_idx_t'(w); // lowest invalid wins
            end
        end
        victim_way = (&valid_ways) ? lru_set[req.addr.index] : first_inv;

        victim_valid = 1'b0;
        victim_tag   = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (victim_way == way_idx_t'(w)) begin
                victim_valid = valid_ways[w];
                victim_tag   = way_tags[w];
            end
        end
        access = hit ? hit_ways : NUM_WAYS'(1) << victim_way;
    end

    assign fill       = req.valid && !hit;
    assign fill_index = req.addr.index;
    assign fill_way   = victim_way;

    generate
        for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
            plru #(
                .NUM_WAYS (NUM_WAYS)
            ) u_plru (
                .clk    (clk),
                .rst_n  (rst_n),
                .access (access),
                .update (req.valid && (req.addr.index == INDEX_W'(s))),
                .lru    (lru_set[s])
            );
        end
    endgenerate

    always_comb begin
        resp_d.valid      = req.valid;
        resp_d.hit        = hit;
        resp_d.way        = hit ? hit_way : victim_way;
        resp_d.evict      = !hit && victim_valid;
        resp_d.victim_tag = victim_tag;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp <= '0;
        end else begin
            resp <= resp_d;
        end
    end

    // lru of a narrow config must never point past the last way
    a_fill_way_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        fill |-> (int'(fill_way) < NUM_WAYS)
    );

endmodule

`default_nettype wire

// File: plru.sv
// tree pseudo-lru for one set
`timescale 1ns/10ps
`default_nettype none

module plru #(
    parameter int NUM_WAYS = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_WAYS-1:0] access,
    input  logic                update,
    output cache_pkg::way_idx_t lru
);

    logic [NUM_WAYS-2:0] state_q;
    logic [NUM_WAYS-2:0] state_d;

    generate
        if (NUM_WAYS == 2) begin : g_two_way
            assign lru = {1'b0, state_q[0]};

            always_comb begin
                state_d    = state_q;
                state_d[0] = access[0]; // point away from the way just used
            end
        end else begin : g_four_way
            // top bit picks the half, bit 1 / bit 0 pick within it
            assign lru = state_q[2] ? {1'b1, state_q[0]} : {1'b0, state_q[1]};

            always_comb begin
                state_d = state_q;
                if (access[3]) begin
                    state_d[2] = 1'b0;
                    state_d[0] = 1'b0;
                end else if (access[2]) begin
                    state_d[2] = 1'b0;
                    state_d[0] = 1'b1;
                end else if (access[1]) begin
                    state_d[2] = 1'b1;
                    state_d[1] = 1'b0;
                end else if (access[0]) begin
                    state_d[2] = 1'b1;
                    state_d[1] = 1'b1;
                end
            end
        end
    endgenerate

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= '0;
        end else if (update) begin
            state_q <= state_d;
        end
    end

    // the controller must hand over exactly one way per update
    a_access_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        update |-> $onehot(access)
    );

endmodule

`default_nettype wire

// File: tag_array.sv
// tag and valid storage
`timescale 1ns/10ps
`default_nettype none

module tag_array #(
    parameter int NUM_WAYS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cache_pkg::INDEX_W-1:0] index,
    input  cache_pkg::tag_t               tag,
    input  logic                          fill,
    input  logic [cache_pkg::INDEX_W-1:0] fill_index,
    input  cache_pkg::way_idx_t           fill_way,
    output logic [NUM_WAYS-1:0]           hit_ways,
    output logic [NUM_WAYS-1:0]           valid_ways,
    output cache_pkg::tag_t               way_tags [NUM_WAYS]
);

    import cache_pkg::*;

    tag_t                tag_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];

    // read side is fully combinational
    always_comb begin
        valid_ways = valid_q[index];
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_tags[w] = tag_mem[index][w];
            hit_ways[w] = valid_q[index][w] && (tag_mem[index][w] == tag);
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill_way == way_idx_t'(w)) begin
                    tag_mem[fill_index][w] <= tag; // fill tag is the request tag
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill_way == way_idx_t'(w)) begin
                    valid_q[fill_index][w] <= 1'b1;
                end
            end
        end
    end

    // fills only go to a missing tag, so no tag lives twice in a set
    a_hit_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(hit_ways)
    );

endmodule

`default_nettype wire

// File: tb_cache_dir.sv
// cache directory testbench
`timescale 1ns/10ps
`default_nettype none

module tb_cache_dir;

    import cache_pkg::*;
    import cpu_pkg::*;

    localparam int    NUM_WAYS   = 4;
    localparam int    MAX_CASES  = 64;
    localparam int    CASE_WORDS = 5; // addr, hit, way, evict, victim tag
    localparam string CASE_FILE  = "lookup_cases.txt";

    logic         clk = 1'b0;
    logic         rst_n;
    lookup_req_t  req;
    lookup_resp_t resp;

    logic [31:0]  case_mem [MAX_CASES*CASE_WORDS];
    int           num_cases;
    int unsigned  cycles      = 0;
    int unsigned  cycle_limit = 32'hffff_ffff; // real limit set once cases are loaded

    cache_dir #(
        .NUM_WAYS (NUM_WAYS)
    ) dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .resp  (resp)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            fail_run("response mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles", cycles));
        end
    end

    task automatic load_cases();
        int fd;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            fail_run({"cannot open data file ", CASE_FILE});
        end else begin
            $fclose(fd);
            for (int i = 0; i < MAX_CASES * CASE_WORDS; i++) begin
                case_mem[i] = 32'hbad0_0000 | 32'(i); // unloaded words sit above 1
            end
            $readmemh(CASE_FILE, case_mem);
            num_cases = 0;
            while (num_cases < MAX_CASES && case_mem[num_cases * CASE_WORDS + 1] <= 32'd1) begin
                num_cases++;
            end
            if (num_cases == 0) begin
                fail_run("data file holds no cases");
            end else begin
                cycle_limit = 2 * num_cases + 20;
            end
        end
    endtask

    task automatic drive_request(input logic valid, input logic [31:0] addr);
        req.valid = valid;
        req.addr  = cache_addr_t'(addr);
    endtask

    task automatic check_response(input int idx);
        int base;
        base = idx * CASE_WORDS;
        compare_field("resp.valid", 32'd1, 32'(resp.valid));
        compare_field("resp.hit", case_mem[base + 1], 32'(resp.hit));
        compare_field("resp.way", case_mem[base + 2], 32'(resp.way));
        compare_field("resp.evict", case_mem[base + 3], 32'(resp.evict));
        if (case_mem[base + 3] != 32'd0) begin // victim tag only counts on evict
            compare_field("resp.victim_tag", case_mem[base + 4], 32'(resp.victim_tag));
        end
    endtask

    initial begin
        rst_n = 1'b0;
        req   = '0;
        load_cases();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (2) begin // idle so no response expected
            @(negedge clk);
            compare_field("resp.valid", 32'd0, 32'(resp.valid));
        end

        // one request per cycle checked a cycle later
        for (int i = 0; i < num_cases; i++) begin
            drive_request(1'b1, case_mem[i * CASE_WORDS]);
            @(negedge clk);
            check_response(i);
        end

        drive_request(1'b0, 32'd0);
        @(negedge clk);
        compare_field("resp.valid", 32'd0, 32'(resp.valid));

        $display("%0d lookups checked", num_cases);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
